//--- include/lsu_params.svh
// Width and cache geometry macros for the load/store unit, included by the package and the RTL.
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Datapath widths.
`define DATA_WIDTH 32
`define ADDR_WIDTH 32
`define TAG_WIDTH 6

// Queue sizes where each entry is addressed by a one-hot select.
`define LQ_DEPTH 8
`define SQ_DEPTH 8

// Direct-mapped data cache geometry.
`define DC_LINES 8
`define DC_LINE_BYTES 16

`endif

//--- rtl/lsu_pkg.sv
// Shared types and decode helpers for the load/store unit, imported by every design unit.
`include "lsu_params.svh"

package lsu_pkg;

    // Address split used by the data cache.
    localparam int DC_OFFSET_W = $clog2(`DC_LINE_BYTES);
    localparam int DC_INDEX_W  = $clog2(`DC_LINES);
    localparam int DC_TAG_W    = `ADDR_WIDTH - DC_INDEX_W - DC_OFFSET_W;
    localparam int WORD_BYTES  = `DATA_WIDTH / 8;
    localparam int BYTE_SEL_W  = $clog2(WORD_BYTES);

    typedef enum logic [3:0] {
        LSU_FUNC_LB,
        LSU_FUNC_LH,
        LSU_FUNC_LW,
        LSU_FUNC_LBU,
        LSU_FUNC_LHU,
        LSU_FUNC_SB,
        LSU_FUNC_SH,
        LSU_FUNC_SW,
        LSU_FUNC_FILL
    } lsu_func_t;

    typedef logic [`ADDR_WIDTH-1:0]      addr_t;
    typedef logic [`DATA_WIDTH-1:0]      data_t;
    typedef logic [`TAG_WIDTH-1:0]       tag_t;
    typedef logic [`DC_LINE_BYTES*8-1:0] cacheline_t;
    typedef logic [`LQ_DEPTH-1:0]        lq_select_t;
    typedef logic [`SQ_DEPTH-1:0]        sq_select_t;

    typedef logic [DC_INDEX_W-1:0]       dc_index_t;
    typedef logic [DC_TAG_W-1:0]         dc_tag_t;

    function automatic logic is_store_func(lsu_func_t func);
        return (func == LSU_FUNC_SB) || (func == LSU_FUNC_SH) || (func == LSU_FUNC_SW);
    endfunction

    // Anything that is neither a store nor a fill is a load.
    function automatic logic is_load_func(lsu_func_t func);
        return !is_store_func(func) && (func != LSU_FUNC_FILL);
    endfunction

endpackage

//--- rtl/lsu_stage_if.sv
// One load/store operation passed between pipeline stages, driven through src and read through dst.
`timescale 1ns/10ps

interface lsu_stage_if;

    import lsu_pkg::*;

    logic       valid;      // Qualifies every other field.
    lsu_func_t  func;
    lq_select_t lq_select;
    sq_select_t sq_select;
    tag_t       tag;
    addr_t      addr;
    logic       retire;
    data_t      store_data;

    modport src (
        output valid,
        output func,
        output lq_select,
        output sq_select,
        output tag,
        output addr,
        output retire,
        output store_data
    );

    modport dst (
        input valid,
        input func,
        input lq_select,
        input sq_select,
        input tag,
        input addr,
        input retire,
        input store_data
    );

endinterface

//--- rtl/lsu_am.sv
// Address generation stage of the LSU, adding base and offset and registering the operation.
`timescale 1ns/10ps

`include "lsu_params.svh"

module lsu_am (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_flush,

    input  logic                   i_valid,
    input  lsu_pkg::lsu_func_t     i_lsu_func,
    input  lsu_pkg::lq_select_t    i_lq_select,
    input  lsu_pkg::sq_select_t    i_sq_select,
    input  lsu_pkg::tag_t          i_tag,
    input  lsu_pkg::addr_t         i_base,
    input  lsu_pkg::addr_t         i_offset,
    input  logic                   i_retire,
    input  lsu_pkg::data_t         i_store_data,

    lsu_stage_if.src               o_op
);

    import lsu_pkg::*;

    addr_t                         addr;
    addr_t                         line_addr;
    addr_t                         op_addr;

    assign addr      = i_base + i_offset;
    assign line_addr = {addr[`ADDR_WIDTH-1:DC_OFFSET_W], {DC_OFFSET_W{1'b0}}};

    // A fill always moves a whole line, so its address points at the line start.
    assign op_addr   = (i_lsu_func == LSU_FUNC_FILL) ? line_addr : addr;

    always_ff @(posedge clk) begin
        if (~n_rst) o_op.valid <= 1'b0;
        else        o_op.valid <= i_valid & ~i_flush;
    end

    always_ff @(posedge clk) begin
        o_op.func       <= i_lsu_func;
        o_op.lq_select  <= i_lq_select;
        o_op.sq_select  <= i_sq_select;
        o_op.tag        <= i_tag;
        o_op.addr       <= op_addr;
        o_op.retire     <= i_retire;
        o_op.store_data <= i_store_data;
    end

    // The queue updates three cycles later rely on at most one entry being selected.
    a_select_onehot: assert property (
        @(posedge clk) disable iff (~n_rst)
        o_op.valid |-> ($onehot0(o_op.lq_select) && $onehot0(o_op.sq_select))
    ) else $error("LSU operation selects more than one queue entry");

endmodule

//--- rtl/lsu_dc.sv
// Direct-mapped write-back data cache stage of the LSU, handling lookup, store write and line fill.
`timescale 1ns/10ps

`include "lsu_params.svh"

module lsu_dc (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_flush,

    lsu_stage_if.dst               i_op,
    input  lsu_pkg::cacheline_t    i_fill_data,

    lsu_stage_if.src               o_op,
    output logic                   o_dc_hit,
    output lsu_pkg::data_t         o_dc_data,
    output logic                   o_dc_victim_valid,
    output logic                   o_dc_victim_dirty,
    output lsu_pkg::addr_t         o_dc_victim_addr,
    output lsu_pkg::cacheline_t    o_dc_victim_data
);

    import lsu_pkg::*;

    dc_tag_t                       tag_q  [`DC_LINES];
    cacheline_t                    data_q [`DC_LINES];
    logic [`DC_LINES-1:0]          valid_q;
    logic [`DC_LINES-1:0]          dirty_q;

    dc_index_t                     index;
    dc_tag_t                       tag;
    logic [DC_OFFSET_W-BYTE_SEL_W-1:0] word_sel;
    logic [BYTE_SEL_W-1:0]         byte_sel;
    logic                          hit;
    data_t                         word;
    data_t                         shifted;
    data_t                         load_word;
    logic                          fill_en;
    logic                          store_en;
    logic [WORD_BYTES-1:0]         word_be;
    data_t                         word_wdata;
    logic [`DC_LINE_BYTES-1:0]     line_be;
    cacheline_t                    line_wdata;

    assign index    = i_op.addr[DC_OFFSET_W +: DC_INDEX_W];
    assign tag      = i_op.addr[`ADDR_WIDTH-1 -: DC_TAG_W];
    assign word_sel = i_op.addr[DC_OFFSET_W-1:BYTE_SEL_W];
    assign byte_sel = i_op.addr[BYTE_SEL_W-1:0];

    assign hit      = valid_q[index] & (tag_q[index] == tag);
    assign word     = data_q[index][word_sel*`DATA_WIDTH +: `DATA_WIDTH];
    assign shifted  = word >> (8 * byte_sel);   // Accessed byte lands in bit 0.

    // Unsigned loads are masked here, signed ones are extended in the execute stage.
    always_comb begin
        case (i_op.func)
            LSU_FUNC_LBU: load_word = {{(`DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            LSU_FUNC_LHU: load_word = {{(`DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            default:      load_word = shifted;
        endcase
    end

    // Store data is replicated over the word and the byte enables pick the lanes.
    always_comb begin
        case (i_op.func)
            LSU_FUNC_SB: begin
                word_be    = WORD_BYTES'(1) << byte_sel;
                word_wdata = {WORD_BYTES{i_op.store_data[7:0]}};
            end
            LSU_FUNC_SH: begin
                word_be    = WORD_BYTES'(3) << byte_sel;
                word_wdata = {(WORD_BYTES/2){i_op.store_data[15:0]}};
            end
            default: begin
                word_be    = '1;
                word_wdata = i_op.store_data;
            end
        endcase
    end

    assign line_be    = `DC_LINE_BYTES'(word_be) << (word_sel * WORD_BYTES);
    assign line_wdata = {(`DC_LINE_BYTES/WORD_BYTES){word_wdata}};

    assign fill_en  = i_op.valid & ~i_flush & (i_op.func == LSU_FUNC_FILL);
    assign store_en = i_op.valid & ~i_flush & is_store_func(i_op.func) & i_op.retire & hit;

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[index] <= i_fill_data;
            tag_q[index]  <= tag;
        end else if (store_en) begin
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (line_be[b]) data_q[index][b*8 +: 8] <= line_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;     // Freshly filled lines match memory.
        end else if (store_en) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) o_op.valid <= 1'b0;
        else        o_op.valid <= i_op.valid & ~i_flush;
    end

    // The victim fields reflect the line before this cycle's write.
    always_ff @(posedge clk) begin
        o_op.func         <= i_op.func;
        o_op.lq_select    <= i_op.lq_select;
        o_op.sq_select    <= i_op.sq_select;
        o_op.tag          <= i_op.tag;
        o_op.addr         <= i_op.addr;
        o_op.retire       <= i_op.retire;
        o_op.store_data   <= i_op.store_data;
        o_dc_hit          <= hit;
        o_dc_data         <= load_word;
        o_dc_victim_valid <= valid_q[index];
        o_dc_victim_dirty <= dirty_q[index];
        o_dc_victim_addr  <= {tag_q[index], index, {DC_OFFSET_W{1'b0}}};
        o_dc_victim_data  <= data_q[index];
    end

    // Fill alignment is done in address generation, and the victim address assumes it.
    a_fill_aligned: assert property (
        @(posedge clk) disable iff (~n_rst)
        (i_op.valid && i_op.func == LSU_FUNC_FILL) |-> (i_op.addr[DC_OFFSET_W-1:0] == '0)
    ) else $error("FILL address is not line aligned");

endmodule

//--- rtl/lsu_ex.sv
// Execute stage of the LSU, producing result broadcasts, queue updates and victim enqueues.
`timescale 1ns/10ps

`include "lsu_params.svh"

module lsu_ex (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_flush,

    lsu_stage_if.dst               i_op,

    input  logic                   i_dc_hit,
    input  lsu_pkg::data_t         i_dc_data,
    input  logic                   i_dc_victim_valid,
    input  logic                   i_dc_victim_dirty,
    input  lsu_pkg::addr_t         i_dc_victim_addr,
    input  lsu_pkg::cacheline_t    i_dc_victim_data,

    output logic                   o_valid,
    output lsu_pkg::data_t         o_data,
    output lsu_pkg::addr_t         o_addr,
    output lsu_pkg::tag_t          o_tag,

    output logic                   o_update_lq_en,
    output lsu_pkg::lq_select_t    o_update_lq_select,
    output logic                   o_update_lq_retry,
    output logic                   o_update_sq_en,
    output lsu_pkg::sq_select_t    o_update_sq_select,
    output logic                   o_update_sq_retry,

    output logic                   o_victim_en,
    output lsu_pkg::addr_t         o_victim_addr,
    output lsu_pkg::cacheline_t    o_victim_data
);

    import lsu_pkg::*;

    logic                          is_fill;
    logic                          is_store;
    logic                          is_load;
    logic                          live;
    data_t                         load_data;

    assign is_fill  = i_op.func == LSU_FUNC_FILL;
    assign is_store = is_store_func(i_op.func);
    assign is_load  = is_load_func(i_op.func);
    assign live     = i_op.valid & ~i_flush;

    // Signed loads are extended here.
    always_comb begin
        case (i_op.func)
            LSU_FUNC_LB: load_data = {{(`DATA_WIDTH-8){i_dc_data[7]}}, i_dc_data[7:0]};
            LSU_FUNC_LH: load_data = {{(`DATA_WIDTH-16){i_dc_data[15]}}, i_dc_data[15:0]};
            default:     load_data = i_dc_data;
        endcase
    end

    always_ff @(posedge clk) begin
        o_data             <= load_data;
        o_addr             <= i_op.addr;
        o_tag              <= i_op.tag;
        o_update_lq_select <= i_op.lq_select;
        o_update_lq_retry  <= ~i_dc_hit;
        o_update_sq_select <= i_op.sq_select;
        o_update_sq_retry  <= ~i_dc_hit;
        o_victim_addr      <= i_dc_victim_addr;
        o_victim_data      <= i_dc_victim_data;
    end

    // Retiring stores were already broadcast at issue.
    always_ff @(posedge clk) begin
        if (~n_rst) o_valid <= 1'b0;
        else        o_valid <= live & ~is_fill & ~i_op.retire & (i_dc_hit | is_store);
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_update_lq_en <= 1'b0;
            o_update_sq_en <= 1'b0;
        end else begin
            o_update_lq_en <= live & is_load;
            o_update_sq_en <= live & i_op.retire;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) o_victim_en <= 1'b0;
        else        o_victim_en <= live & is_fill & i_dc_victim_valid & i_dc_victim_dirty;
    end

    // A fill never produces a result, so the victim path and the broadcast never collide.
    a_victim_no_broadcast: assert property (
        @(posedge clk) disable iff (~n_rst)
        !(o_victim_en && o_valid)
    ) else $error("Victim enqueue and broadcast in the same cycle");

endmodule

//--- rtl/lsu_top.sv
// Top level of the LSU back end, chaining address generation, data cache and execute stages.
`timescale 1ns/10ps

module lsu_top (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_flush,

    input  logic                   i_valid,
    input  lsu_pkg::lsu_func_t     i_lsu_func,
    input  lsu_pkg::lq_select_t    i_lq_select,
    input  lsu_pkg::sq_select_t    i_sq_select,
    input  lsu_pkg::tag_t          i_tag,
    input  lsu_pkg::addr_t         i_base,
    input  lsu_pkg::addr_t         i_offset,
    input  logic                   i_retire,
    input  lsu_pkg::data_t         i_store_data,
    input  lsu_pkg::cacheline_t    i_fill_data,

    output logic                   o_valid,
    output lsu_pkg::data_t         o_data,
    output lsu_pkg::addr_t         o_addr,
    output lsu_pkg::tag_t          o_tag,

    output logic                   o_update_lq_en,
    output lsu_pkg::lq_select_t    o_update_lq_select,
    output logic                   o_update_lq_retry,
    output logic                   o_update_sq_en,
    output lsu_pkg::sq_select_t    o_update_sq_select,
    output logic                   o_update_sq_retry,

    output logic                   o_victim_en,
    output lsu_pkg::addr_t         o_victim_addr,
    output lsu_pkg::cacheline_t    o_victim_data
);

    import lsu_pkg::*;

    logic                          dc_hit;
    data_t                         dc_data;
    logic                          dc_victim_valid;
    logic                          dc_victim_dirty;
    addr_t                         dc_victim_addr;
    cacheline_t                    dc_victim_data;

    lsu_stage_if am_dc ();
    lsu_stage_if dc_ex ();

    lsu_am u_am (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_valid            (i_valid),
        .i_lsu_func         (i_lsu_func),
        .i_lq_select        (i_lq_select),
        .i_sq_select        (i_sq_select),
        .i_tag              (i_tag),
        .i_base             (i_base),
        .i_offset           (i_offset),
        .i_retire           (i_retire),
        .i_store_data       (i_store_data),
        .o_op               (am_dc.src)
    );

    lsu_dc u_dc (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_op               (am_dc.dst),
        .i_fill_data        (i_fill_data),  // Fill data is sampled while the FILL is in this stage.
        .o_op               (dc_ex.src),
        .o_dc_hit           (dc_hit),
        .o_dc_data          (dc_data),
        .o_dc_victim_valid  (dc_victim_valid),
        .o_dc_victim_dirty  (dc_victim_dirty),
        .o_dc_victim_addr   (dc_victim_addr),
        .o_dc_victim_data   (dc_victim_data)
    );

    lsu_ex u_ex (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_op               (dc_ex.dst),
        .i_dc_hit           (dc_hit),
        .i_dc_data          (dc_data),
        .i_dc_victim_valid  (dc_victim_valid),
        .i_dc_victim_dirty  (dc_victim_dirty),
        .i_dc_victim_addr   (dc_victim_addr),
        .i_dc_victim_data   (dc_victim_data),
        .o_valid            (o_valid),
        .o_data             (o_data),
        .o_addr             (o_addr),
        .o_tag              (o_tag),
        .o_update_lq_en     (o_update_lq_en),
        .o_update_lq_select (o_update_lq_select),
        .o_update_lq_retry  (o_update_lq_retry),
        .o_update_sq_en     (o_update_sq_en),
        .o_update_sq_select (o_update_sq_select),
        .o_update_sq_retry  (o_update_sq_retry),
        .o_victim_en        (o_victim_en),
        .o_victim_addr      (o_victim_addr),
        .o_victim_data      (o_victim_data)
    );

endmodule

//--- bench/lsu_tb.sv
// Table-driven testbench for the LSU top level, checking each row against a cache model.
`timescale 1ns/10ps

`include "lsu_params.svh"

module lsu_tb;

    import lsu_pkg::*;

    typedef struct {
        logic       valid;
        lsu_func_t  func;
        addr_t      base;
        addr_t      offset;
        logic       retire;
        logic       flush;
        data_t      store_data;
        lq_select_t lq_select;
        sq_select_t sq_select;
        tag_t       tag;
        cacheline_t fill_data;
    } row_t;

    typedef struct packed {
        logic       valid;
        logic       has_data;   // Only load broadcasts carry meaningful data.
        data_t      data;
        addr_t      addr;
        tag_t       tag;
        logic       lq_en;
        lq_select_t lq_select;
        logic       lq_retry;
        logic       sq_en;
        sq_select_t sq_select;
        logic       sq_retry;
        logic       victim_en;
        addr_t      victim_addr;
        cacheline_t victim_data;
    } expect_t;

    logic       clk;
    logic       n_rst;
    logic       i_flush;
    logic       i_valid;
    lsu_func_t  i_lsu_func;
    lq_select_t i_lq_select;
    sq_select_t i_sq_select;
    tag_t       i_tag;
    addr_t      i_base;
    addr_t      i_offset;
    logic       i_retire;
    data_t      i_store_data;
    cacheline_t i_fill_data;

    logic       o_valid;
    data_t      o_data;
    addr_t      o_addr;
    tag_t       o_tag;
    logic       o_update_lq_en;
    lq_select_t o_update_lq_select;
    logic       o_update_lq_retry;
    logic       o_update_sq_en;
    sq_select_t o_update_sq_select;
    logic       o_update_sq_retry;
    logic       o_victim_en;
    addr_t      o_victim_addr;
    cacheline_t o_victim_data;

    row_t       rows[$];
    expect_t    pending[$];     // Results due three cycles after their row.

    logic       m_valid [`DC_LINES];
    logic       m_dirty [`DC_LINES];
    addr_t      m_line  [`DC_LINES];
    cacheline_t m_data  [`DC_LINES];

    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         cycle_limit = 0;

    lsu_top u_dut (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_valid            (i_valid),
        .i_lsu_func         (i_lsu_func),
        .i_lq_select        (i_lq_select),
        .i_sq_select        (i_sq_select),
        .i_tag              (i_tag),
        .i_base             (i_base),
        .i_offset           (i_offset),
        .i_retire           (i_retire),
        .i_store_data       (i_store_data),
        .i_fill_data        (i_fill_data),
        .o_valid            (o_valid),
        .o_data             (o_data),
        .o_addr             (o_addr),
        .o_tag              (o_tag),
        .o_update_lq_en     (o_update_lq_en),
        .o_update_lq_select (o_update_lq_select),
        .o_update_lq_retry  (o_update_lq_retry),
        .o_update_sq_en     (o_update_sq_en),
        .o_update_sq_select (o_update_sq_select),
        .o_update_sq_retry  (o_update_sq_retry),
        .o_victim_en        (o_victim_en),
        .o_victim_addr      (o_victim_addr),
        .o_victim_data      (o_victim_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped at cycle %0d before the table was finished.", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input cacheline_t got, input cacheline_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_select(input string name, input lq_select_t got, input lq_select_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic addr_t line_of(addr_t a);
        return a & ~addr_t'(`DC_LINE_BYTES - 1);
    endfunction

    function automatic logic [7:0] byte_at(cacheline_t line, int off);
        return line[(off % `DC_LINE_BYTES) * 8 +: 8];
    endfunction

    // Loads take bytes little-endian from the line and extend them by function.
    function automatic data_t load_value(lsu_func_t func, cacheline_t line, int off);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = byte_at(line, off);
        b1 = byte_at(line, off + 1);
        case (func)
            LSU_FUNC_LB:  return {{(`DATA_WIDTH-8){b0[7]}}, b0};
            LSU_FUNC_LBU: return {{(`DATA_WIDTH-8){1'b0}}, b0};
            LSU_FUNC_LH:  return {{(`DATA_WIDTH-16){b1[7]}}, b1, b0};
            LSU_FUNC_LHU: return {{(`DATA_WIDTH-16){1'b0}}, b1, b0};
            default:      return {byte_at(line, off + 3), byte_at(line, off + 2), b1, b0};
        endcase
    endfunction

    function automatic logic flush_at(int k);
        return (k < rows.size()) ? rows[k].flush : 1'b0;
    endfunction

    task automatic add_row(input logic valid, input lsu_func_t func, input addr_t base,
                           input addr_t offset, input logic retire, input logic flush);
        row_t r;
        r.valid      = valid;
        r.func       = func;
        r.base       = base;
        r.offset     = offset;
        r.retire     = retire;
        r.flush      = flush;
        r.store_data = $urandom();
        r.lq_select  = lq_select_t'(1) << (rows.size() % `LQ_DEPTH);
        r.sq_select  = sq_select_t'(1) << ((rows.size() + 3) % `SQ_DEPTH);
        r.tag        = tag_t'(rows.size());
        for (int w = 0; w < `DC_LINE_BYTES / 4; w++) begin
            r.fill_data[w*32 +: 32] = $urandom();
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        addr_t line_a;
        addr_t line_b;
        addr_t line_c;
        line_a = 32'h0000_1040;
        line_b = 32'h0000_2040;     // Same index as line_a with another tag.
        line_c = 32'h0000_1080;
        add_row(0, LSU_FUNC_LW, '0, '0, 0, 0);
        add_row(0, LSU_FUNC_LW, '0, '0, 0, 0);
        add_row(1, LSU_FUNC_LW, line_a, 0, 0, 0);
        add_row(1, LSU_FUNC_FILL, line_a, 8, 0, 0);
        add_row(1, LSU_FUNC_LW, line_a, 4, 0, 0);
        add_row(1, LSU_FUNC_LB, line_a, 1, 0, 0);
        add_row(1, LSU_FUNC_LH, line_a, 2, 0, 0);
        add_row(1, LSU_FUNC_LBU, line_a, 3, 0, 0);
        add_row(1, LSU_FUNC_LHU, line_a, 4, 0, 0);
        add_row(1, LSU_FUNC_SW, line_a, 8, 0, 0);
        add_row(1, LSU_FUNC_SW, line_a, 8, 1, 0);
        add_row(1, LSU_FUNC_LW, line_a, 8, 0, 0);
        add_row(1, LSU_FUNC_SB, line_a, 13, 1, 0);
        add_row(1, LSU_FUNC_LBU, line_a, 13, 0, 0);
        add_row(1, LSU_FUNC_SH, line_a, 10, 1, 0);
        add_row(1, LSU_FUNC_LH, line_a + 32'h10, 32'hFFFF_FFFA, 0, 0);
        add_row(1, LSU_FUNC_SW, line_c, 0, 0, 0);
        add_row(1, LSU_FUNC_SW, line_b, 8, 1, 0);
        add_row(1, LSU_FUNC_LW, line_a, 8, 0, 0);
        add_row(1, LSU_FUNC_FILL, line_b, 0, 0, 0);
        add_row(1, LSU_FUNC_LW, line_b, 0, 0, 0);
        add_row(1, LSU_FUNC_FILL, line_b, 0, 0, 0);
        add_row(1, LSU_FUNC_FILL, line_c, 0, 0, 0);
        add_row(1, LSU_FUNC_LW, line_c, 4, 0, 0);
        add_row(1, LSU_FUNC_SW, line_c, 8, 1, 0);
        add_row(1, LSU_FUNC_SW, line_c, 12, 1, 1);
        add_row(0, LSU_FUNC_LW, '0, '0, 0, 0);
        add_row(1, LSU_FUNC_LW, line_c, 8, 0, 0);
        add_row(1, LSU_FUNC_LW, line_c, 12, 0, 0);
        add_row(1, LSU_FUNC_SW, line_c, 0, 1, 0);
        add_row(1, LSU_FUNC_LW, line_c, 0, 0, 0);
        add_row(1, LSU_FUNC_LB, line_c, 0, 0, 0);
        add_row(1, LSU_FUNC_FILL, line_c, 0, 0, 0);
        add_row(1, LSU_FUNC_LW, line_a, 0, 0, 0);
        for (int i = 0; i < 3; i++) begin
            add_row(0, LSU_FUNC_LW, '0, '0, 0, 0);
        end
    endtask

    // Steps the cache model by one row and returns what the outputs show for it.
    task automatic predict(input int k, output expect_t e);
        row_t      r;
        addr_t     a;
        dc_index_t idx;
        int        off;
        int        nbytes;
        logic      hit;
        logic      is_fill;
        logic      is_store;
        logic      is_load;
        logic      no_write;
        logic      killed;
        r        = rows[k];
        e        = '0;
        is_fill  = (r.func == LSU_FUNC_FILL);
        is_store = (r.func == LSU_FUNC_SB) || (r.func == LSU_FUNC_SH) || (r.func == LSU_FUNC_SW);
        is_load  = !is_fill && !is_store;
        a        = r.base + r.offset;
        if (is_fill) a = line_of(a);
        idx      = a[DC_OFFSET_W +: DC_INDEX_W];
        off      = int'(a[DC_OFFSET_W-1:0]);
        hit      = m_valid[idx] && (m_line[idx] == line_of(a));
        no_write = r.flush || flush_at(k + 1);      // Flush catches it in the first two stages.
        killed   = no_write || flush_at(k + 2);
        if (!r.valid) return;
        if (!killed) begin
            e.valid       = !is_fill && !r.retire && (hit || is_store);
            e.has_data    = e.valid && is_load;
            e.data        = load_value(r.func, m_data[idx], off);
            e.addr        = a;
            e.tag         = r.tag;
            e.lq_en       = is_load;
            e.lq_select   = r.lq_select;
            e.lq_retry    = !hit;
            e.sq_en       = r.retire;
            e.sq_select   = r.sq_select;
            e.sq_retry    = !hit;
            e.victim_en   = is_fill && m_valid[idx] && m_dirty[idx];
            e.victim_addr = m_line[idx];
            e.victim_data = m_data[idx];
        end
        if (!no_write && is_fill) begin
            m_valid[idx] = 1'b1;
            m_dirty[idx] = 1'b0;
            m_line[idx]  = a;
            m_data[idx]  = r.fill_data;
        end else if (!no_write && is_store && r.retire && hit) begin
            nbytes = (r.func == LSU_FUNC_SB) ? 1 : (r.func == LSU_FUNC_SH) ? 2 : 4;
            for (int i = 0; i < nbytes; i++) begin
                m_data[idx][(off + i) * 8 +: 8] = r.store_data[i*8 +: 8];
            end
            m_dirty[idx] = 1'b1;
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_bit("o_valid", o_valid, e.valid);
        if (e.valid) begin
            check_addr("o_addr", o_addr, e.addr);
            check_tag("o_tag", o_tag, e.tag);
        end
        if (e.has_data) check_data("o_data", o_data, e.data);
        check_bit("o_update_lq_en", o_update_lq_en, e.lq_en);
        if (e.lq_en) begin
            check_select("o_update_lq_select", o_update_lq_select, e.lq_select);
            check_bit("o_update_lq_retry", o_update_lq_retry, e.lq_retry);
        end
        check_bit("o_update_sq_en", o_update_sq_en, e.sq_en);
        if (e.sq_en) begin
            check_select("o_update_sq_select", o_update_sq_select, e.sq_select);
            check_bit("o_update_sq_retry", o_update_sq_retry, e.sq_retry);
        end
        check_bit("o_victim_en", o_victim_en, e.victim_en);
        if (e.victim_en) begin
            check_addr("o_victim_addr", o_victim_addr, e.victim_addr);
            check_line("o_victim_data", o_victim_data, e.victim_data);
        end
    endtask

    initial begin
        row_t       r;
        expect_t    e;
        cacheline_t prev_fill;
        clk          = 1'b0;
        n_rst        = 1'b0;
        i_flush      = 1'b0;
        i_valid      = 1'b0;
        i_lsu_func   = LSU_FUNC_LW;
        i_lq_select  = '0;
        i_sq_select  = '0;
        i_tag        = '0;
        i_base       = '0;
        i_offset     = '0;
        i_retire     = 1'b0;
        i_store_data = '0;
        i_fill_data  = '0;
        prev_fill    = '0;
        for (int i = 0; i < `DC_LINES; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_line[i]  = '0;
            m_data[i]  = '0;
        end
        void'($urandom(22317));
        build_table();
        cycle_limit = rows.size() + 20;

        repeat (2) @(posedge clk);
        n_rst <= 1'b1;

        for (int k = 0; k < rows.size(); k++) begin
            @(posedge clk);
            r = rows[k];
            i_valid      <= r.valid;
            i_lsu_func   <= r.func;
            i_base       <= r.base;
            i_offset     <= r.offset;
            i_retire     <= r.retire;
            i_flush      <= r.flush;
            i_store_data <= r.store_data;
            i_lq_select  <= r.lq_select;
            i_sq_select  <= r.sq_select;
            i_tag        <= r.tag;
            i_fill_data  <= prev_fill;      // The cache stage takes fill data one cycle later.
            prev_fill = r.fill_data;
            predict(k, e);
            pending.push_back(e);
            @(negedge clk);
            if (pending.size() > 3) check_outputs(pending.pop_front());
        end

        $display("Run complete with %0d checks and %0d errors.", checks, errors);
        if (errors == 0) $display("Testbench passed");
        else $display("Testbench failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_stage_if.sv
rtl/lsu_am.sv
rtl/lsu_dc.sv
rtl/lsu_ex.sv
rtl/lsu_top.sv
bench/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Builds the LSU testbench with Verilator, runs it and looks for the pass line in the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module lsu_tb -Mdir obj_dir -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
echo "Simulation log holds no pass line."
exit 1
